//--- compile.f
+incdir+.
tlb_pkg.sv
tlb_way_ram.sv
tlb_lookup.sv
tlb_axil_ctrl.sv
tlb_top.sv
tb_tlb.sv

//--- tb_tlb.sv
// testbench for tlb_top that drives AXI4-Lite and the lookup port from one process
// bready is held high and rready is lowered only inside the read task
// the shadow model decodes entries from the TAG and DATA register words
`include "tlb_settings.svh"

module tb_tlb;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	// reset and clear walk plus about 40 cycles per AXI transfer and per lookup plus margin
	localparam int N_AXI = 240;
	localparam int N_LOOKUP = 240;
	localparam int TIMEOUT_CYCLES = 8 + `TLB_SETS + 40 * (N_AXI + N_LOOKUP) + 1000;

	logic clk_g;
	logic rst_i;
	logic [4:0] s_awaddr_i, s_araddr_i;
	logic s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o;
	logic [31:0] s_wdata_i, s_rdata_o;
	logic [3:0] s_wstrb_i;
	logic [1:0] s_bresp_o, s_rresp_o;
	logic s_bvalid_o, s_bready_i, s_arvalid_i, s_arready_o, s_rvalid_o, s_rready_i;
	logic req_valid_i, ready_o, resp_valid_o, resp_hit_o, resp_fault_o;
	logic [31:0] req_va_i, resp_pa_o;
	logic [7:0] req_asid_i;
	logic [1:0] req_kind_i;

	// shadow of the TAG and DATA words committed to each way and set
	logic [31:0] shadow_tag [`TLB_WAYS][`TLB_SETS];
	logic [31:0] shadow_data [`TLB_WAYS][`TLB_SETS];
	logic [31:0] exp_miss_va;
	// expected {hit, fault, pa} and the edge where the DUT took the request
	logic [33:0] exp_q [$];
	int iss_q [$];
	logic [33:0] exp_word;
	int exp_issue;
	int cyc = 0;
	int checks = 0;
	int errors = 0;
	int test_err0;

	tlb_top u_tlb_top (.*);

	initial begin
		clk_g = 1'b0;
		forever #20 clk_g = ~clk_g;
	end

	// cycle count and run limit
	always @(posedge clk_g) begin
		cyc <= cyc + 1;
		if (cyc > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, a handshake or response never came", cyc);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// expected result for one lookup where the first matching way wins
	function automatic logic [33:0] tlb_ref(input logic [31:0] va, input logic [7:0] asid,
		input logic [1:0] kind);
		logic [5:0] sidx;
		logic [31:0] tw;
		logic [31:0] dw;
		logic [2:0] perm;
		logic hit;
		logic fault;
		logic [31:0] pa;
		hit = 1'b0;
		fault = 1'b0;
		pa = '0;
		sidx = va[17:12];
		for (int w = 0; w < `TLB_WAYS; w++) begin
			tw = shadow_tag[w][sidx];
			dw = shadow_data[w][sidx];
			perm = dw[22:20];
			// valid, tag, then asid unless global
			if (!hit && dw[24] && (tw[19:6] == va[31:18]) && (dw[23] || tw[27:20] == asid)) begin
				hit = 1'b1;
				fault = !perm[kind];
				pa = {dw[19:0], va[11:0]};
			end
		end
		if (!hit) begin
			exp_miss_va = va;
		end
		return {hit, fault, pa};
	endfunction

	// ==============================
	// AXI4-Lite and lookup drivers
	// ==============================
	task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		s_awaddr_i <= addr;
		s_awvalid_i <= 1'b1;
		s_wdata_i <= data;
		s_wvalid_i <= 1'b1;
		@(posedge clk_g);
		while (!s_awready_o) @(posedge clk_g);
		// address and data are taken in the same cycle
		check_value("s_wready_o", s_wready_o, 32'h1);
		s_awvalid_i <= 1'b0;
		s_wvalid_i <= 1'b0;
		@(posedge clk_g);
		while (!s_bvalid_o) @(posedge clk_g);
		resp = s_bresp_o;
	endtask

	// hold keeps rready low for that many cycles once rvalid is up
	task automatic axi_read(input logic [4:0] addr, input int hold, output logic [31:0] data,
		output logic [1:0] resp);
		s_rready_i <= (hold == 0);
		s_araddr_i <= addr;
		s_arvalid_i <= 1'b1;
		@(posedge clk_g);
		while (!s_arready_o) @(posedge clk_g);
		s_arvalid_i <= 1'b0;
		@(posedge clk_g);
		while (!s_rvalid_o) @(posedge clk_g);
		data = s_rdata_o;
		resp = s_rresp_o;
		if (hold != 0) begin
			repeat (hold) begin
				@(posedge clk_g);
				checks++;
				assert (s_rvalid_o) else begin
					$display("Error at %0t: rvalid dropped while rready was low", $time);
					errors++;
				end
				check_value("s_rdata_o while stalled", s_rdata_o, data);
			end
			s_rready_i <= 1'b1;
			@(posedge clk_g);
		end
	endtask

	// TAG, DATA, then CMD naming the way
	task automatic commit_entry(input int way, input logic [19:0] vpn, input logic [7:0] asid,
		input logic [19:0] ppn, input logic [2:0] perm, input logic glob, input logic valid);
		logic [31:0] tag_w;
		logic [31:0] data_w;
		logic [1:0] resp;
		tag_w = {4'h0, asid, vpn};
		data_w = {7'h0, valid, glob, perm, ppn};
		axi_write(`TLB_REG_TAG, tag_w, resp);
		check_value("s_bresp_o TAG", resp, RESP_OKAY);
		axi_write(`TLB_REG_DATA, data_w, resp);
		check_value("s_bresp_o DATA", resp, RESP_OKAY);
		axi_write(`TLB_REG_CMD, way, resp);
		check_value("s_bresp_o CMD", resp, RESP_OKAY);
		shadow_tag[way][vpn[5:0]] = tag_w;
		shadow_data[way][vpn[5:0]] = data_w;
	endtask

	// drives one request on this edge and leaves the clock to the caller
	task automatic issue_lookup(input logic [31:0] va, input logic [7:0] asid,
		input logic [1:0] kind);
		req_valid_i <= 1'b1;
		req_va_i <= va;
		req_asid_i <= asid;
		req_kind_i <= kind;
		exp_q.push_back(tlb_ref(va, asid, kind));
		iss_q.push_back(cyc + 1);
	endtask

	task automatic wait_drain();
		req_valid_i <= 1'b0;
		while (exp_q.size() != 0) @(posedge clk_g);
		@(posedge clk_g);
	endtask

	task automatic begin_test();
		test_err0 = errors;
	endtask

	task automatic report_test(input string name);
		if (errors == test_err0) $display("test %s: ok", name);
		else $display("test %s: %0d errors", name, errors - test_err0);
	endtask

	// ==============================
	// response checker
	// ==============================
	always @(posedge clk_g) begin
		if (!rst_i && resp_valid_o === 1'b1) begin
			checks++;
			assert (exp_q.size() != 0) else begin
				$display("Error at %0t: response came with no request outstanding", $time);
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp_word = exp_q.pop_front();
				exp_issue = iss_q.pop_front();
				check_value("resp_hit_o", resp_hit_o, exp_word[33]);
				check_value("resp_fault_o", resp_fault_o, exp_word[32]);
				check_value("resp_pa_o", resp_pa_o, exp_word[31:0]);
				check_value("response latency", cyc - exp_issue, 2);
			end
		end
	end

	// ==============================
	// stimulus
	// ==============================
	initial begin
		int seed;
		int n;
		int sidx;
		logic [1:0] resp;
		logic [31:0] rdata;
		logic [31:0] va;
		seed = 32'h5286;
		void'($urandom(seed));
		rst_i = 1'b1;
		s_awaddr_i = '0;
		s_awvalid_i = 1'b0;
		s_wdata_i = '0;
		s_wstrb_i = 4'hF;
		s_wvalid_i = 1'b0;
		s_bready_i = 1'b1;
		s_araddr_i = '0;
		s_arvalid_i = 1'b0;
		s_rready_i = 1'b1;
		req_valid_i = 1'b0;
		req_va_i = '0;
		req_asid_i = '0;
		req_kind_i = '0;
		exp_miss_va = '0;
		for (int w = 0; w < `TLB_WAYS; w++) begin
			for (int s = 0; s < `TLB_SETS; s++) begin
				shadow_tag[w][s] = '0;
				shadow_data[w][s] = '0;
			end
		end
		repeat (8) @(posedge clk_g);
		rst_i <= 1'b0;

		// clear walk then misses everywhere
		begin_test();
		n = 0;
		while (ready_o !== 1'b1) begin
			@(posedge clk_g);
			n++;
		end
		checks++;
		assert (n >= `TLB_SETS) else begin
			$display("Error at %0t: ready_o rose %0d cycles after reset, before the clear ended",
				$time, n);
			errors++;
		end
		for (int i = 0; i < 8; i++) begin
			issue_lookup($urandom, $urandom_range(0, 255), $urandom_range(0, 2));
			@(posedge clk_g);
		end
		wait_drain();
		axi_read(`TLB_REG_MISS, 0, rdata, resp);
		check_value("s_rresp_o MISS", resp, RESP_OKAY);
		check_value("s_rdata_o MISS", rdata, exp_miss_va);
		report_test("1 clear and miss");

		// one entry with hit and PA
		begin_test();
		commit_entry(1, 20'h12345, 8'h3A, 20'hABCDE, 3'b111, 1'b0, 1'b1);
		issue_lookup({20'h12345, 12'h5A5}, 8'h3A, 2'd0);
		@(posedge clk_g);
		issue_lookup({20'h22345, 12'h010}, 8'h3A, 2'd0);
		@(posedge clk_g);
		wait_drain();
		report_test("2 commit and hit");

		// asid match then a global entry
		begin_test();
		issue_lookup({20'h12345, 12'h004}, 8'h3B, 2'd1);
		@(posedge clk_g);
		wait_drain();
		commit_entry(2, 20'h0F0F3, 8'h11, 20'h55555, 3'b101, 1'b1, 1'b1);
		issue_lookup({20'h0F0F3, 12'h000}, 8'h00, 2'd0);
		@(posedge clk_g);
		issue_lookup({20'h0F0F3, 12'h7FF}, 8'h11, 2'd2);
		@(posedge clk_g);
		issue_lookup({20'h0F0F3, 12'hFFF}, 8'hFF, 2'd1);
		@(posedge clk_g);
		wait_drain();
		report_test("3 asid and global");

		// every permission pattern against every access kind
		begin_test();
		for (int p = 0; p < 8; p++) begin
			commit_entry(3, {14'h1F0, 6'(32 + p)}, 8'h05, 20'h01000 + p, p, 1'b0, 1'b1);
		end
		for (int p = 0; p < 8; p++) begin
			for (int k = 0; k < 3; k++) begin
				issue_lookup({14'h1F0, 6'(32 + p), 12'h123}, 8'h05, k);
				@(posedge clk_g);
			end
		end
		wait_drain();
		report_test("4 permissions");

		// small tag and asid pools so ways often hold the same tag
		begin_test();
		for (int s = 0; s < 16; s++) begin
			for (int w = 0; w < `TLB_WAYS; w++) begin
				commit_entry(w, {14'(14'h2A0 + $urandom_range(0, 2)), 6'(s)},
					$urandom_range(1, 3), $urandom, $urandom_range(0, 7),
					$urandom_range(0, 3) == 0, $urandom_range(0, 7) != 0);
			end
		end
		for (int i = 0; i < 200; i++) begin
			sidx = $urandom_range(0, 17);
			va = {14'(14'h2A0 + $urandom_range(0, 3)), 6'(sidx), 12'($urandom)};
			issue_lookup(va, $urandom_range(1, 3), $urandom_range(0, 2));
			@(posedge clk_g);
		end
		wait_drain();
		report_test("5 random stream");

		// error responses and staged readback under rready stall
		begin_test();
		axi_write(5'h10, 32'h1, resp);
		check_value("s_bresp_o unmapped", resp, RESP_SLVERR);
		axi_write(`TLB_REG_MISS, 32'h1, resp);
		check_value("s_bresp_o MISS", resp, RESP_SLVERR);
		axi_read(5'h14, 0, rdata, resp);
		check_value("s_rresp_o unmapped", resp, RESP_SLVERR);
		check_value("s_rdata_o unmapped", rdata, 32'h0);
		axi_write(`TLB_REG_TAG, 32'hF5A5A123, resp);
		check_value("s_bresp_o TAG staging", resp, RESP_OKAY);
		axi_write(`TLB_REG_DATA, 32'hFFC31234, resp);
		check_value("s_bresp_o DATA staging", resp, RESP_OKAY);
		axi_read(`TLB_REG_TAG, 5, rdata, resp);
		check_value("s_rresp_o TAG", resp, RESP_OKAY);
		check_value("s_rdata_o TAG", rdata, 32'hF5A5A123 & 32'h0FFFFFFF);
		axi_read(`TLB_REG_DATA, 3, rdata, resp);
		check_value("s_rresp_o DATA", resp, RESP_OKAY);
		check_value("s_rdata_o DATA", rdata, 32'hFFC31234 & 32'h01FFFFFF);
		report_test("6 register errors and readback");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- tlb_axil_ctrl.sv
// AXI4-Lite register port, entry commit and reset clear walk
// wstrb is ignored, every write is taken as a full 32-bit write
// all ready signals stay low for the 64-cycle clear walk after reset
// CMD reads back as zero, MISS is read-only
`include "tlb_settings.svh"

module tlb_axil_ctrl (
	input  logic                          clk_g,
	input  logic                          rst_i,
	input  logic [`TLB_AXI_ADDR_BITS-1:0] s_awaddr_i,
	input  logic                          s_awvalid_i,
	output logic                          s_awready_o,
	input  logic [31:0]                   s_wdata_i,
	input  logic [3:0]                    s_wstrb_i,
	input  logic                          s_wvalid_i,
	output logic                          s_wready_o,
	output logic [1:0]                    s_bresp_o,
	output logic                          s_bvalid_o,
	input  logic                          s_bready_i,
	input  logic [`TLB_AXI_ADDR_BITS-1:0] s_araddr_i,
	input  logic                          s_arvalid_i,
	output logic                          s_arready_o,
	output logic [31:0]                   s_rdata_o,
	output logic [1:0]                    s_rresp_o,
	output logic                          s_rvalid_o,
	input  logic                          s_rready_i,
	output logic                          ready_o,
	output logic [`TLB_WAYS-1:0]          ram_we_o,
	output tlb_pkg::set_idx_t             ram_idx_o,
	output tlb_pkg::tlb_entry_t           ram_entry_o,
	input  logic                          miss_i,
	input  tlb_pkg::vaddr_t               miss_va_i
);
	import tlb_pkg::*;

	ctrl_state_e state_q;
	set_idx_t    clr_idx_q;
	// trails the FSM by one cycle so the last clear write lands first
	logic        ready_q;

	// staged TAG and DATA fields
	vpn_t   tag_vpn_q;
	asid_t  tag_asid_q;
	ppn_t   dat_ppn_q;
	perm_t  dat_perm_q;
	logic   dat_global_q;
	logic   dat_valid_q;
	vaddr_t miss_va_q;

	logic     wr_fire;
	logic     rd_fire;
	way_idx_t cmd_way;

	// ==============================
	// handshakes
	// ==============================
	// address and data must arrive together, one response outstanding
	assign wr_fire = ready_q && s_awvalid_i && s_wvalid_i && !s_bvalid_o;
	assign rd_fire = ready_q && s_arvalid_i && !s_rvalid_o;
	assign s_awready_o = wr_fire;
	assign s_wready_o = wr_fire;
	assign s_arready_o = rd_fire;
	assign ready_o = ready_q;
	assign cmd_way = s_wdata_i[`TLB_WAY_BITS-1:0];

	// ==============================
	// FSM and way write enables
	// ==============================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			state_q <= ST_CLEAR;
			clr_idx_q <= '0;
			ready_q <= 1'b0;
			ram_we_o <= '0;
		end else begin
			ready_q <= (state_q == ST_RUN);
			ram_we_o <= '0;
			case (state_q)
				ST_CLEAR: begin
					// every way at once, one set per cycle
					ram_we_o <= '1;
					clr_idx_q <= clr_idx_q + 1'b1;
					if (&clr_idx_q) begin
						state_q <= ST_RUN;
					end
				end
				ST_RUN: begin
					// CMD write lands in the ram on the next edge
					if (wr_fire && (s_awaddr_i == `TLB_REG_CMD)) begin
						ram_we_o[cmd_way] <= 1'b1;
					end
				end
				default: state_q <= ST_CLEAR;
			endcase
		end
	end

	// write payload, zero entry while clearing
	always_ff @(posedge clk_g) begin
		if (state_q == ST_CLEAR) begin
			ram_idx_o <= clr_idx_q;
			ram_entry_o <= '0;
		end else begin
			ram_idx_o <= tag_vpn_q[`TLB_SET_BITS-1:0];
			ram_entry_o <= {dat_valid_q, dat_global_q, dat_perm_q, tag_asid_q, dat_ppn_q,
				tag_vpn_q[`TLB_VPN_BITS-1 -: `TLB_TAG_BITS]};
		end
	end

	// ==============================
	// write channel and staging registers
	// ==============================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			s_bvalid_o <= 1'b0;
			s_bresp_o <= `TLB_RESP_OKAY;
			tag_vpn_q <= '0;
			tag_asid_q <= '0;
			dat_ppn_q <= '0;
			dat_perm_q <= '0;
			dat_global_q <= 1'b0;
			dat_valid_q <= 1'b0;
		end else begin
			if (s_bvalid_o && s_bready_i) begin
				s_bvalid_o <= 1'b0;
			end
			if (wr_fire) begin
				s_bvalid_o <= 1'b1;
				s_bresp_o <= `TLB_RESP_OKAY;
				case (s_awaddr_i)
					// vpn in 19:0, asid in 27:20
					`TLB_REG_TAG: begin
						tag_vpn_q <= s_wdata_i[`TLB_VPN_BITS-1:0];
						tag_asid_q <= s_wdata_i[`TLB_VPN_BITS +: `TLB_ASID_BITS];
					end
					// ppn in 19:0, rwx in 22:20, global 23, valid 24
					`TLB_REG_DATA: begin
						dat_ppn_q <= s_wdata_i[`TLB_PPN_BITS-1:0];
						dat_perm_q <= s_wdata_i[`TLB_PPN_BITS +: 3];
						dat_global_q <= s_wdata_i[`TLB_PPN_BITS + 3];
						dat_valid_q <= s_wdata_i[`TLB_PPN_BITS + 4];
					end
					`TLB_REG_CMD: begin
						// commit handled by the FSM
					end
					default: s_bresp_o <= `TLB_RESP_SLVERR;
				endcase
			end
		end
	end

	// ==============================
	// read channel
	// ==============================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			s_rvalid_o <= 1'b0;
			s_rresp_o <= `TLB_RESP_OKAY;
			s_rdata_o <= '0;
		end else begin
			if (s_rvalid_o && s_rready_i) begin
				s_rvalid_o <= 1'b0;
			end
			if (rd_fire) begin
				s_rvalid_o <= 1'b1;
				s_rresp_o <= `TLB_RESP_OKAY;
				s_rdata_o <= '0;
				case (s_araddr_i)
					`TLB_REG_TAG: s_rdata_o <= 32'({tag_asid_q, tag_vpn_q});
					`TLB_REG_DATA: s_rdata_o <= 32'({dat_valid_q, dat_global_q, dat_perm_q,
						dat_ppn_q});
					`TLB_REG_CMD: s_rdata_o <= '0;
					`TLB_REG_MISS: s_rdata_o <= miss_va_q;
					default: s_rresp_o <= `TLB_RESP_SLVERR;
				endcase
			end
		end
	end

	// most recent miss, software visible
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			miss_va_q <= '0;
		end else if (miss_i) begin
			miss_va_q <= miss_va_i;
		end
	end

	// single way on commit, every way only during the clear walk
	a_we_shape: assert property (@(posedge clk_g) disable iff (rst_i)
		$onehot0(ram_we_o) || ((&ram_we_o) && !ready_q));

	// write response held until taken
	a_bvalid_hold: assert property (@(posedge clk_g) disable iff (rst_i)
		(s_bvalid_o && !s_bready_i) |=> s_bvalid_o);

	// partial writes are not supported
	a_full_strobe: assert property (@(posedge clk_g) disable iff (rst_i)
		wr_fire |-> (&s_wstrb_i));

endmodule

//--- tlb_lookup.sv
// two-stage lookup, a request sampled at edge N is answered at edge N+2
// no back-pressure, a new request may be taken every cycle
// access kind 3 is reserved and faults on every hit
`include "tlb_settings.svh"

module tlb_lookup (
	input  logic                clk_g,
	input  logic                rst_i,
	input  logic                req_valid_i,
	input  tlb_pkg::vaddr_t     req_va_i,
	input  tlb_pkg::asid_t      req_asid_i,
	input  tlb_pkg::acc_kind_t  req_kind_i,
	output logic                ram_re_o,
	output tlb_pkg::set_idx_t   ram_idx_o,
	input  tlb_pkg::tlb_entry_t way_entry_i [`TLB_WAYS],
	output logic                resp_valid_o,
	output logic                resp_hit_o,
	output logic                resp_fault_o,
	output tlb_pkg::paddr_t     resp_pa_o,
	output logic                miss_o,
	output tlb_pkg::vaddr_t     miss_va_o
);
	import tlb_pkg::*;

	// stage 1 state, in step with the ram read
	logic      s1_valid;
	vaddr_t    s1_va;
	asid_t     s1_asid;
	acc_kind_t s1_kind;

	// per-way fields and the winning way
	logic [`TLB_WAYS-1:0] way_match;
	ppn_t  way_ppn [`TLB_WAYS];
	perm_t way_perm [`TLB_WAYS];
	logic  hit;
	ppn_t  hit_ppn;
	perm_t hit_perm;
	logic  perm_ok;

	// ==============================
	// stage 1: set index and request capture
	// ==============================
	assign ram_re_o = req_valid_i;
	assign ram_idx_o = req_va_i[`TLB_PAGE_BITS +: `TLB_SET_BITS];

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= req_valid_i;
		end
	end

	always_ff @(posedge clk_g) begin
		s1_va <= req_va_i;
		s1_asid <= req_asid_i;
		s1_kind <= req_kind_i;
	end

	// ==============================
	// stage 2: compare, pick, check
	// ==============================
	for (genvar w = 0; w < `TLB_WAYS; w++) begin : g_match
		logic  e_valid;
		logic  e_global;
		asid_t e_asid;
		vtag_t e_tag;

		assign {e_valid, e_global, way_perm[w], e_asid, way_ppn[w], e_tag} = way_entry_i[w];
		// global entries ignore the asid
		assign way_match[w] = e_valid
			&& (e_tag == s1_va[`TLB_VA_BITS-1 -: `TLB_TAG_BITS])
			&& (e_global || (e_asid == s1_asid));
	end

	always_comb begin
		hit = 1'b0;
		hit_ppn = '0;
		hit_perm = '0;
		// scan downward so the lowest matching way is kept
		for (int w = `TLB_WAYS - 1; w >= 0; w--) begin
			if (way_match[w]) begin
				hit = 1'b1;
				hit_ppn = way_ppn[w];
				hit_perm = way_perm[w];
			end
		end
		case (s1_kind)
			ACC_READ: perm_ok = hit_perm[0];
			ACC_WRITE: perm_ok = hit_perm[1];
			ACC_EXEC: perm_ok = hit_perm[2];
			default: perm_ok = 1'b0;
		endcase
	end

	// response flags, the miss pulse lasts one cycle per missing request
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			resp_valid_o <= 1'b0;
			resp_hit_o <= 1'b0;
			resp_fault_o <= 1'b0;
			miss_o <= 1'b0;
		end else begin
			resp_valid_o <= s1_valid;
			resp_hit_o <= s1_valid && hit;
			resp_fault_o <= s1_valid && hit && !perm_ok;
			miss_o <= s1_valid && !hit;
		end
	end

	// pa is ppn joined with the page offset, zero on a miss
	always_ff @(posedge clk_g) begin
		resp_pa_o <= hit ? {hit_ppn, s1_va[`TLB_PAGE_BITS-1:0]} : '0;
		miss_va_o <= s1_va;
	end

	// each request ends two edges later as exactly one of hit or miss
	a_resp_outcome: assert property (@(posedge clk_g) disable iff (rst_i)
		req_valid_i |-> ##2 (resp_valid_o && (resp_hit_o != miss_o)));

	// hit and miss stay low between responses
	a_resp_quiet: assert property (@(posedge clk_g) disable iff (rst_i)
		!resp_valid_o |-> !(resp_hit_o || miss_o));

endmodule

//--- tlb_pkg.sv
// field types for the TLB
// permission bits are ordered read, write, execute from bit 0 up
`include "tlb_settings.svh"

package tlb_pkg;

	// addresses and page numbers
	typedef logic [`TLB_VA_BITS-1:0] vaddr_t;
	typedef logic [`TLB_PA_BITS-1:0] paddr_t;
	typedef logic [`TLB_VPN_BITS-1:0] vpn_t;
	typedef logic [`TLB_PPN_BITS-1:0] ppn_t;
	typedef logic [`TLB_ASID_BITS-1:0] asid_t;

	// set index is the low part of the vpn, the tag is the rest
	typedef logic [`TLB_SET_BITS-1:0] set_idx_t;
	typedef logic [`TLB_TAG_BITS-1:0] vtag_t;
	typedef logic [`TLB_WAY_BITS-1:0] way_idx_t;
	typedef logic [2:0] perm_t;

	// stored entry, top down: valid, global, perm, asid, ppn, tag
	typedef logic [`TLB_ENTRY_BITS-1:0] tlb_entry_t;

	// access kind presented with each lookup
	typedef logic [1:0] acc_kind_t;
	localparam acc_kind_t ACC_READ = 2'd0;
	localparam acc_kind_t ACC_WRITE = 2'd1;
	localparam acc_kind_t ACC_EXEC = 2'd2;

	// controller FSM
	typedef enum logic [0:0] {
		ST_CLEAR,
		ST_RUN
	} ctrl_state_e;

endpackage

//--- tlb_settings.svh
// widths, geometry and register map shared by the package and the RTL
// way and set counts must stay powers of two, pages are fixed at 4 KB
`ifndef TLB_SETTINGS_SVH
`define TLB_SETTINGS_SVH

// geometry
`define TLB_WAYS 4
`define TLB_WAY_BITS 2
`define TLB_SET_BITS 6
`define TLB_SETS (1 << `TLB_SET_BITS)

// address widths
`define TLB_VA_BITS 32
`define TLB_PA_BITS 32
`define TLB_PAGE_BITS 12
`define TLB_ASID_BITS 8
`define TLB_VPN_BITS (`TLB_VA_BITS - `TLB_PAGE_BITS)
`define TLB_PPN_BITS (`TLB_PA_BITS - `TLB_PAGE_BITS)
`define TLB_TAG_BITS (`TLB_VPN_BITS - `TLB_SET_BITS)
// valid, global, rwx, asid, ppn, tag
`define TLB_ENTRY_BITS (5 + `TLB_ASID_BITS + `TLB_PPN_BITS + `TLB_TAG_BITS)

// AXI4-Lite register map, byte offsets
`define TLB_AXI_ADDR_BITS 5
`define TLB_REG_TAG 5'h00
`define TLB_REG_DATA 5'h04
`define TLB_REG_CMD 5'h08
`define TLB_REG_MISS 5'h0C
`define TLB_RESP_OKAY 2'b00
`define TLB_RESP_SLVERR 2'b10

`endif

//--- tlb_top.sv
// TLB top, AXI4-Lite entry loading, per-way storage and the lookup pipeline
// ready_o stays low for the 64-cycle clear walk after reset
// a lookup made while ready_o is low gives an undefined result
`include "tlb_settings.svh"

module tlb_top (
	input  logic                          clk_g,
	input  logic                          rst_i,
	input  logic [`TLB_AXI_ADDR_BITS-1:0] s_awaddr_i,
	input  logic                          s_awvalid_i,
	output logic                          s_awready_o,
	input  logic [31:0]                   s_wdata_i,
	input  logic [3:0]                    s_wstrb_i,
	input  logic                          s_wvalid_i,
	output logic                          s_wready_o,
	output logic [1:0]                    s_bresp_o,
	output logic                          s_bvalid_o,
	input  logic                          s_bready_i,
	input  logic [`TLB_AXI_ADDR_BITS-1:0] s_araddr_i,
	input  logic                          s_arvalid_i,
	output logic                          s_arready_o,
	output logic [31:0]                   s_rdata_o,
	output logic [1:0]                    s_rresp_o,
	output logic                          s_rvalid_o,
	input  logic                          s_rready_i,
	input  logic                          req_valid_i,
	input  tlb_pkg::vaddr_t               req_va_i,
	input  tlb_pkg::asid_t                req_asid_i,
	input  tlb_pkg::acc_kind_t            req_kind_i,
	output logic                          ready_o,
	output logic                          resp_valid_o,
	output logic                          resp_hit_o,
	output logic                          resp_fault_o,
	output tlb_pkg::paddr_t               resp_pa_o
);
	import tlb_pkg::*;

	// write side, shared by all ways
	logic [`TLB_WAYS-1:0] ram_we;
	set_idx_t   ram_wr_idx;
	tlb_entry_t ram_wr_entry;
	// read side
	logic       ram_re;
	set_idx_t   ram_rd_idx;
	tlb_entry_t way_rd [`TLB_WAYS];
	// miss report into the MISS register
	logic       miss;
	vaddr_t     miss_va;

	tlb_axil_ctrl u_ctrl (
		.clk_g(clk_g), .rst_i(rst_i),
		.s_awaddr_i(s_awaddr_i), .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o),
		.s_wdata_i(s_wdata_i), .s_wstrb_i(s_wstrb_i), .s_wvalid_i(s_wvalid_i),
		.s_wready_o(s_wready_o),
		.s_bresp_o(s_bresp_o), .s_bvalid_o(s_bvalid_o), .s_bready_i(s_bready_i),
		.s_araddr_i(s_araddr_i), .s_arvalid_i(s_arvalid_i), .s_arready_o(s_arready_o),
		.s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o), .s_rvalid_o(s_rvalid_o),
		.s_rready_i(s_rready_i),
		.ready_o(ready_o),
		.ram_we_o(ram_we), .ram_idx_o(ram_wr_idx), .ram_entry_o(ram_wr_entry),
		.miss_i(miss), .miss_va_i(miss_va)
	);

	// one storage block per way, same set read from all of them
	for (genvar w = 0; w < `TLB_WAYS; w++) begin : g_way
		tlb_way_ram u_ram (
			.clk_g(clk_g),
			.we_i(ram_we[w]), .wr_idx_i(ram_wr_idx), .wr_entry_i(ram_wr_entry),
			.re_i(ram_re), .rd_idx_i(ram_rd_idx), .rd_entry_o(way_rd[w])
		);
	end

	tlb_lookup u_lookup (
		.clk_g(clk_g), .rst_i(rst_i),
		.req_valid_i(req_valid_i), .req_va_i(req_va_i),
		.req_asid_i(req_asid_i), .req_kind_i(req_kind_i),
		.ram_re_o(ram_re), .ram_idx_o(ram_rd_idx), .way_entry_i(way_rd),
		.resp_valid_o(resp_valid_o), .resp_hit_o(resp_hit_o),
		.resp_fault_o(resp_fault_o), .resp_pa_o(resp_pa_o),
		.miss_o(miss), .miss_va_o(miss_va)
	);

endmodule

//--- tlb_way_ram.sv
// storage for one TLB way, one entry per set, contents have no reset
// registered read, a same-cycle write to the read set returns the old entry
`include "tlb_settings.svh"

module tlb_way_ram (
	input  logic                clk_g,
	input  logic                we_i,
	input  tlb_pkg::set_idx_t   wr_idx_i,
	input  tlb_pkg::tlb_entry_t wr_entry_i,
	input  logic                re_i,
	input  tlb_pkg::set_idx_t   rd_idx_i,
	output tlb_pkg::tlb_entry_t rd_entry_o
);
	import tlb_pkg::*;

	tlb_entry_t mem [`TLB_SETS];

	// write port, commit or clear walk
	always_ff @(posedge clk_g) begin
		if (we_i) begin
			mem[wr_idx_i] <= wr_entry_i;
		end
	end

	// read port
	// nonblocking read sees the contents from before this edge
	always_ff @(posedge clk_g) begin
		if (re_i) begin
			rd_entry_o <= mem[rd_idx_i];
		end
	end

endmodule
